// File: clio_assertions.sv
`timescale 1ns/100ps
`include "clio_defs.svh"

module clio_assertions (
	input logic clk_25m,
	input logic reset_n,
	input logic cpu_wr,
	input logic firq_n,
	input clio_pkg::beam_count_t hcnt,
	input clio_pkg::beam_count_t vcnt,
	input logic field,
	input logic [1:0] vint_hit,
	input clio_pkg::reg_word_t pend0 // bank 0 pending view
);

	int err_count = 0; // tb watches this every clock

	// nothing pending or enabled out of reset, fiq stays idle
	firq_idle_after_reset: assert property (@(posedge clk_25m) $rose(reset_n) |-> firq_n)
	else begin
		err_count++;
		$error("ERR firq_n after reset exp 1 got %h", $sampled(firq_n));
	end

	frame_wrap: assert property (@(posedge clk_25m) disable iff (!reset_n)
		hcnt == `CLIO_HCNT_MAX && vcnt == `CLIO_VCNT_MAX && !cpu_wr
		|=> hcnt == 0 && vcnt == 0 && field != $past(field)) // last pixel of the frame
	else begin
		err_count++;
		$error("ERR hcnt %h vcnt %h field %h after frame wrap, exp 0 0 and field flipped",
			$sampled(hcnt), $sampled(vcnt), $sampled(field));
	end

	// a line match pends irq0 bit 0 or 1 at the next edge
	vint_pends: assert property (@(posedge clk_25m) disable iff (!reset_n)
		vint_hit != 2'b00 && !cpu_wr
		|=> (pend0[1:0] & $past(vint_hit)) == $past(vint_hit))
	else begin
		err_count++;
		$error("ERR pend0[1:0] after vint hit exp %h got %h",
			$past(vint_hit), $sampled(pend0[1:0]));
	end

endmodule

// File: clio_beam_counter.sv
`timescale 1ns/100ps
`include "clio_defs.svh"

module clio_beam_counter (
	input logic clk_25m,
	input logic reset_n,
	input logic hcnt_load, // host write to hcnt
	input logic vcnt_load, // host write to vcnt
	input clio_pkg::reg_word_t load_data,
	input clio_pkg::beam_count_t vint0,
	input clio_pkg::beam_count_t vint1,
	output clio_pkg::beam_count_t hcnt,
	output clio_pkg::beam_count_t vcnt,
	output logic field, // flips every frame
	output logic [1:0] vint_hit // line match, one clock at hcnt 0
);

	logic h_wrap; // last clock of the line
	logic v_wrap; // last line of the frame

	assign h_wrap = (hcnt == `CLIO_HCNT_MAX);
	assign v_wrap = (vcnt == `CLIO_VCNT_MAX);

	always_ff @(posedge clk_25m or negedge reset_n) begin
		if (!reset_n) begin
			hcnt <= '0;
			vcnt <= '0;
			field <= 1'b0;
		end else begin
			if (hcnt_load)
				hcnt <= load_data[10:0]; // host beats the counter
			else if (h_wrap)
				hcnt <= '0;
			else
				hcnt <= hcnt + 1'b1;

			if (vcnt_load) begin
				vcnt <= load_data[10:0];
			end else if (h_wrap) begin
				if (v_wrap) begin
					vcnt <= '0;
					field <= ~field; // new field
				end else begin
					vcnt <= vcnt + 1'b1;
				end
			end
		end
	end

	// start of line compare, feeds irq0 bits 0 and 1
	assign vint_hit[0] = (hcnt == '0) && (vcnt == vint0);
	assign vint_hit[1] = (hcnt == '0) && (vcnt == vint1);

endmodule

// File: clio_ctrl_regs.sv
`timescale 1ns/100ps
`include "clio_defs.svh"

module clio_ctrl_regs (
	input logic clk_25m,
	input logic reset_n,
	input logic cpu_wr, // single cycle strobe
	input clio_pkg::reg_addr_t cpu_addr,
	input clio_pkg::reg_word_t cpu_din,
	output clio_pkg::bank_bits_t pend_set, // per bank, cpu_din is the mask
	output clio_pkg::bank_bits_t pend_clr,
	output clio_pkg::bank_bits_t en_set,
	output clio_pkg::bank_bits_t en_clr,
	output logic hcnt_load, // to beam counter
	output logic vcnt_load,
	output clio_pkg::beam_count_t vint0, // line compare values
	output clio_pkg::beam_count_t vint1,
	output clio_pkg::reg_word_t revision,
	output clio_pkg::reg_word_t csysbits,
	output clio_pkg::reg_word_t cstatbits,
	output clio_pkg::reg_word_t mode,
	output clio_pkg::reg_word_t expctl
);
	import clio_pkg::*;

	logic [15:0] waddr; // byte address of this write

	assign waddr = byte_addr(cpu_addr);
	assign revision = `CLIO_REVISION_RESET; // read only, writes dropped

	assign hcnt_load = cpu_wr && (waddr == `CLIO_A_HCNT);
	assign vcnt_load = cpu_wr && (waddr == `CLIO_A_VCNT);

	// set/clear strobes for each irq bank
	always_comb begin
		for (int b = 0; b < `CLIO_IRQ_BANKS; b++) begin
			pend_set[b] = cpu_wr && (waddr == bank_addr(b, `CLIO_A_IRQ0_SET));
			pend_clr[b] = cpu_wr && (waddr == bank_addr(b, `CLIO_A_IRQ0_CLR));
			en_set[b] = cpu_wr && (waddr == bank_addr(b, `CLIO_A_EN0_SET));
			en_clr[b] = cpu_wr && (waddr == bank_addr(b, `CLIO_A_EN0_CLR));
		end
	end

	always_ff @(posedge clk_25m or negedge reset_n) begin
		if (!reset_n) begin
			csysbits <= '0;
			cstatbits <= `CLIO_CSTAT_RESET; // por bit up
			vint0 <= '0;
			vint1 <= '0;
			mode <= '0;
			expctl <= `CLIO_EXPCTL_RESET;
		end else if (cpu_wr) begin
			case (waddr)
				`CLIO_A_CSYSBITS: csysbits <= cpu_din;
				`CLIO_A_CSTATBITS: cstatbits <= cpu_din;
				`CLIO_A_VINT0: vint0 <= cpu_din[10:0]; // only the line number
				`CLIO_A_VINT1: vint1 <= cpu_din[10:0];
				`CLIO_A_MODE_SET: mode <= mode | cpu_din;
				`CLIO_A_MODE_CLR: mode <= mode & ~cpu_din;
				`CLIO_A_EXP_SET: expctl <= expctl | cpu_din;
				`CLIO_A_EXP_CLR: expctl <= expctl & ~cpu_din;
				default: ; // banks and beam handled elsewhere
			endcase
		end
	end

endmodule

// File: clio_defs.svh
`ifndef CLIO_DEFS_SVH
`define CLIO_DEFS_SVH

`define CLIO_IRQ_BANKS 2 // irq0 and irq1
`define CLIO_BANK_STRIDE 16'h0020 // irq1 regs sit 0x20 above irq0

// raster limits
`define CLIO_HCNT_MAX 11'd1590 // last pixel clock of a line
`define CLIO_VCNT_MAX 11'd262 // last line of a field
`define CLIO_FIELD_SHIFT 11 // field bit position in vcnt read

// power-on values
`define CLIO_REVISION_RESET 32'h0202_0000 // chip rev in top byte
`define CLIO_EXPCTL_RESET 32'h0000_0080 // arm owns the expansion bus
`define CLIO_CSTAT_RESET 32'h0000_0001 // por flag
`define CLIO_UNMAPPED_DATA 32'hBADA_CCE5 // returned for holes in the map

// byte addresses, cpu_addr is the word address above these
`define CLIO_A_REVISION 16'h0000
`define CLIO_A_CSYSBITS 16'h0004
`define CLIO_A_VINT0 16'h0008
`define CLIO_A_VINT1 16'h000C
`define CLIO_A_CSTATBITS 16'h0028
`define CLIO_A_HCNT 16'h0030
`define CLIO_A_VCNT 16'h0034
`define CLIO_A_IRQ0_SET 16'h0040
`define CLIO_A_IRQ0_CLR 16'h0044
`define CLIO_A_EN0_SET 16'h0048
`define CLIO_A_EN0_CLR 16'h004C
`define CLIO_A_MODE_SET 16'h0050
`define CLIO_A_MODE_CLR 16'h0054
`define CLIO_A_IRQ1_SET 16'h0060
`define CLIO_A_IRQ1_CLR 16'h0064
`define CLIO_A_EN1_SET 16'h0068
`define CLIO_A_EN1_CLR 16'h006C
`define CLIO_A_EXP_SET 16'h0400
`define CLIO_A_EXP_CLR 16'h0404

`endif

// File: clio_irq_bank.sv
`timescale 1ns/100ps

module clio_irq_bank #(
	parameter bit chain_top = 1'b0 // 1 on irq0 where the top bit shows the next bank
) (
	input logic clk_25m,
	input logic reset_n,
	input logic pend_set, // host set/clear strobes
	input logic pend_clr,
	input logic en_set,
	input logic en_clr,
	input clio_pkg::reg_word_t wdata, // write mask
	input clio_pkg::reg_word_t hw_set, // hardware interrupt sources
	input logic chain_in, // any_pend of the next bank
	output clio_pkg::reg_word_t pend_view,
	output clio_pkg::reg_word_t enable,
	output logic any_pend,
	output logic trig
);
	import clio_pkg::*;

	reg_word_t pend; // raw pending bits

	always_ff @(posedge clk_25m or negedge reset_n) begin
		if (!reset_n) begin
			pend <= '0;
			enable <= '0;
		end else begin
			if (pend_set)
				pend <= pend | wdata; // host write wins over hw_set
			else if (pend_clr)
				pend <= pend & ~wdata;
			else
				pend <= pend | hw_set;

			if (en_set)
				enable <= enable | wdata;
			else if (en_clr)
				enable <= enable & ~wdata;
		end
	end

	// irq0 bit 31 reads as "something pending in irq1"
	assign pend_view = chain_top ? {chain_in, pend[30:0]} : pend;

	assign trig = |(pend_view & enable);
	assign any_pend = |pend; // raw bits rather than the chained view

endmodule

// File: clio_pkg.sv
`include "clio_defs.svh"

package clio_pkg;

	typedef logic [31:0] reg_word_t; // host register word
	typedef logic [13:0] reg_addr_t; // word address, byte addr [15:2]
	typedef logic [10:0] beam_count_t; // hpos, vpos, vint compare
	typedef logic [`CLIO_IRQ_BANKS-1:0] bank_bits_t; // one bit per irq bank

	// word address back to the byte map
	function automatic logic [15:0] byte_addr(input reg_addr_t waddr);
		return {waddr, 2'b00};
	endfunction

	// bank-0 register address moved up to bank b
	function automatic logic [15:0] bank_addr(input int unsigned b, input logic [15:0] base0);
		logic [15:0] offs;
		offs = 16'(b) * `CLIO_BANK_STRIDE;
		return base0 + offs;
	endfunction

endpackage

// File: clio_read_fiq.sv
`timescale 1ns/100ps
`include "clio_defs.svh"

module clio_read_fiq (
	input clio_pkg::reg_addr_t cpu_addr,
	input clio_pkg::reg_word_t revision,
	input clio_pkg::reg_word_t csysbits,
	input clio_pkg::beam_count_t vint0,
	input clio_pkg::beam_count_t vint1,
	input clio_pkg::reg_word_t cstatbits,
	input clio_pkg::reg_word_t mode,
	input clio_pkg::reg_word_t expctl,
	input clio_pkg::beam_count_t hcnt,
	input clio_pkg::beam_count_t vcnt,
	input logic field,
	input clio_pkg::reg_word_t pend_view [`CLIO_IRQ_BANKS], // per bank
	input clio_pkg::reg_word_t enable [`CLIO_IRQ_BANKS],
	input clio_pkg::bank_bits_t trig,
	output clio_pkg::reg_word_t cpu_dout,
	output logic firq_n // to the arm, low = fiq
);
	import clio_pkg::*;

	logic [15:0] raddr; // byte address being read
	reg_word_t vcnt_word; // vpos with field on top

	assign raddr = byte_addr(cpu_addr);
	assign vcnt_word = reg_word_t'(vcnt) | (reg_word_t'(field) << `CLIO_FIELD_SHIFT);

	always_comb begin
		cpu_dout = `CLIO_UNMAPPED_DATA; // hole in the map
		case (raddr)
			`CLIO_A_REVISION: cpu_dout = revision;
			`CLIO_A_CSYSBITS: cpu_dout = csysbits;
			`CLIO_A_VINT0: cpu_dout = reg_word_t'(vint0);
			`CLIO_A_VINT1: cpu_dout = reg_word_t'(vint1);
			`CLIO_A_CSTATBITS: cpu_dout = cstatbits;
			`CLIO_A_HCNT: cpu_dout = reg_word_t'(hcnt);
			`CLIO_A_VCNT: cpu_dout = vcnt_word;
			`CLIO_A_MODE_SET, `CLIO_A_MODE_CLR: cpu_dout = mode; // pair reads same reg
			`CLIO_A_EXP_SET, `CLIO_A_EXP_CLR: cpu_dout = expctl;
			default: ;
		endcase
		// bank registers, set and clear read alike
		for (int b = 0; b < `CLIO_IRQ_BANKS; b++) begin
			if (raddr == bank_addr(b, `CLIO_A_IRQ0_SET) ||
				raddr == bank_addr(b, `CLIO_A_IRQ0_CLR))
				cpu_dout = pend_view[b];
			if (raddr == bank_addr(b, `CLIO_A_EN0_SET) ||
				raddr == bank_addr(b, `CLIO_A_EN0_CLR))
				cpu_dout = enable[b];
		end
	end

	assign firq_n = ~|trig; // any bank with pending & enabled

endmodule

// File: clio_top.sv
`timescale 1ns/100ps
`include "clio_defs.svh"

module clio_top (
	input logic clk_25m,
	input logic reset_n,
	input logic cpu_wr,
	input clio_pkg::reg_addr_t cpu_addr,
	input clio_pkg::reg_word_t cpu_din,
	output clio_pkg::reg_word_t cpu_dout,
	output logic firq_n
);
	import clio_pkg::*;

	bank_bits_t pend_set, pend_clr, en_set, en_clr; // host strobes per bank
	bank_bits_t any_pend;
	bank_bits_t trig;
	logic hcnt_load;
	logic vcnt_load;
	beam_count_t vint0, vint1;
	beam_count_t hcnt, vcnt;
	logic field;
	logic [1:0] vint_hit;
	reg_word_t revision, csysbits, cstatbits, mode, expctl;
	reg_word_t pend_view [`CLIO_IRQ_BANKS];
	reg_word_t enable [`CLIO_IRQ_BANKS];

	clio_ctrl_regs ctrl0 (
		.clk_25m(clk_25m), .reset_n(reset_n),
		.cpu_wr(cpu_wr), .cpu_addr(cpu_addr), .cpu_din(cpu_din),
		.pend_set(pend_set), .pend_clr(pend_clr), .en_set(en_set), .en_clr(en_clr),
		.hcnt_load(hcnt_load), .vcnt_load(vcnt_load),
		.vint0(vint0), .vint1(vint1),
		.revision(revision), .csysbits(csysbits), .cstatbits(cstatbits),
		.mode(mode), .expctl(expctl)
	);

	clio_beam_counter beam0 (
		.clk_25m(clk_25m), .reset_n(reset_n),
		.hcnt_load(hcnt_load), .vcnt_load(vcnt_load), .load_data(cpu_din),
		.vint0(vint0), .vint1(vint1),
		.hcnt(hcnt), .vcnt(vcnt), .field(field), .vint_hit(vint_hit)
	);

	for (genvar g = 0; g < `CLIO_IRQ_BANKS; g++) begin : g_bank
		reg_word_t hw_set; // hardware sources into this bank
		logic chain_in;

		if (g == 0) begin : g_src
			assign hw_set = {30'd0, vint_hit}; // vint0/vint1 on irq0 bits 0,1
		end else begin : g_nosrc
			assign hw_set = '0;
		end

		if (g == `CLIO_IRQ_BANKS - 1) begin : g_last
			assign chain_in = 1'b0; // nothing behind the last bank
		end else begin : g_chain
			assign chain_in = any_pend[g + 1];
		end

		clio_irq_bank #(.chain_top(g == 0)) bank (
			.clk_25m(clk_25m), .reset_n(reset_n),
			.pend_set(pend_set[g]), .pend_clr(pend_clr[g]),
			.en_set(en_set[g]), .en_clr(en_clr[g]),
			.wdata(cpu_din), .hw_set(hw_set), .chain_in(chain_in),
			.pend_view(pend_view[g]), .enable(enable[g]),
			.any_pend(any_pend[g]), .trig(trig[g])
		);
	end

	clio_read_fiq rd0 (
		.cpu_addr(cpu_addr),
		.revision(revision), .csysbits(csysbits), .vint0(vint0), .vint1(vint1),
		.cstatbits(cstatbits), .mode(mode), .expctl(expctl),
		.hcnt(hcnt), .vcnt(vcnt), .field(field),
		.pend_view(pend_view), .enable(enable), .trig(trig),
		.cpu_dout(cpu_dout), .firq_n(firq_n)
	);

endmodule

// File: list.f
+incdir+.
clio_pkg.sv
clio_ctrl_regs.sv
clio_beam_counter.sv
clio_irq_bank.sv
clio_read_fiq.sv
clio_top.sv
clio_assertions.sv
tb_clio.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the CLIO register core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_clio
./obj_dir/Vtb_clio +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log || ! grep -q "STATUS: PASS" sim.log; then
	exit 1
fi

// File: tb_clio.sv
`timescale 1ns/100ps
`include "clio_defs.svh"

module tb_clio;
	import clio_pkg::*;

	localparam int max_cycles = 2 * 263 * 1591; // line test may wait up to a frame

	logic clk_25m = 1'b0;
	logic reset_n = 1'b0;
	logic cpu_wr = 1'b0;
	reg_addr_t cpu_addr = '0;
	reg_word_t cpu_din = '0;
	reg_word_t cpu_dout;
	logic firq_n;
	int cycles = 0;
	reg_word_t rec [6]; // mode, expctl, en0, en1, pend0, pend1 as written
	logic [15:0] sc_addr [12] = '{`CLIO_A_MODE_SET, `CLIO_A_MODE_CLR, `CLIO_A_EXP_SET,
		`CLIO_A_EXP_CLR, `CLIO_A_EN0_SET, `CLIO_A_EN0_CLR, `CLIO_A_EN1_SET,
		`CLIO_A_EN1_CLR, `CLIO_A_IRQ0_SET, `CLIO_A_IRQ0_CLR, `CLIO_A_IRQ1_SET,
		`CLIO_A_IRQ1_CLR}; // set at even index and clear at odd with rec at half the index

	clio_top dut0 (
		.clk_25m(clk_25m), .reset_n(reset_n), .cpu_wr(cpu_wr), .cpu_addr(cpu_addr),
		.cpu_din(cpu_din), .cpu_dout(cpu_dout), .firq_n(firq_n)
	);

	bind clio_top clio_assertions chk0 (
		.clk_25m(clk_25m), .reset_n(reset_n), .cpu_wr(cpu_wr), .firq_n(firq_n),
		.hcnt(hcnt), .vcnt(vcnt), .field(field), .vint_hit(vint_hit),
		.pend0(pend_view[0])
	);

	always #20 clk_25m = ~clk_25m; // 25 MHz

	always @(posedge clk_25m) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("STATUS: FAIL");
			$fatal(1, "timeout, the run did not finish within %0d cycles", max_cycles);
		end else if (dut0.chk0.err_count != 0) begin
			$display("STATUS: FAIL");
			$fatal(1, "stopped on a failed bound assertion");
		end
	end

	// top bit of bank 0 mirrors "bank 1 has something pending"
	function automatic reg_word_t pend0_view();
		return {|rec[5], rec[4][30:0]};
	endfunction

	function automatic logic firq_n_expected();
		return !(|(pend0_view() & rec[2]) || |(rec[5] & rec[3]));
	endfunction

	task automatic write_reg(input logic [15:0] baddr, input reg_word_t data);
		cpu_wr = 1'b1;
		cpu_addr = baddr[15:2];
		cpu_din = data;
		@(posedge clk_25m);
		#1 cpu_wr = 1'b0; // addr kept so dout shows the new value
	endtask

	task automatic read_reg(input logic [15:0] baddr);
		cpu_addr = baddr[15:2];
		@(posedge clk_25m);
		#1;
	endtask

	task automatic check_word(input string name, input reg_word_t got, input reg_word_t exp);
		assert (got === exp)
		else begin
			$display("ERR %s exp %h got %h", name, exp, got);
			$display("STATUS: FAIL");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	initial begin
		int idx;
		int r;
		int line;
		int waited;
		reg_word_t mask;

		void'($urandom(35));
		rec = '{32'd0, `CLIO_EXPCTL_RESET, 32'd0, 32'd0, 32'd0, 32'd0};
		repeat (10) @(posedge clk_25m);
		#1 reset_n = 1'b1;

		check_word("firq_n", firq_n, 32'd1);
		read_reg(`CLIO_A_REVISION);
		check_word("cpu_dout revision", cpu_dout, `CLIO_REVISION_RESET);
		read_reg(`CLIO_A_EXP_SET);
		check_word("cpu_dout expctl", cpu_dout, rec[1]);
		read_reg(`CLIO_A_CSTATBITS);
		check_word("cpu_dout cstatbits", cpu_dout, `CLIO_CSTAT_RESET);
		read_reg(16'h1000 + 16'(($urandom % 256) * 4)); // hole above the map
		check_word("cpu_dout unmapped", cpu_dout, `CLIO_UNMAPPED_DATA);

		write_reg(`CLIO_A_IRQ0_CLR, '1); // drop the line 0 vint hits
		for (int i = 0; i < 40; i++) begin
			idx = (i < 12) ? i : $urandom % 12; // every address once before random picks
			r = idx / 2;
			mask = (r >= 4) ? (32'd1 << ($urandom % 32)) : $urandom; // sparse irq bits
			write_reg(sc_addr[idx], mask);
			rec[r] = (idx % 2 == 0) ? (rec[r] | mask) : (rec[r] & ~mask);
			check_word("cpu_dout set/clear", cpu_dout, (r == 4) ? pend0_view() : rec[r]);
			check_word("firq_n", firq_n, firq_n_expected());
		end

		mask = 32'd1 << ($urandom % 31);
		write_reg(`CLIO_A_IRQ1_SET, mask);
		rec[5] = rec[5] | mask;
		read_reg(`CLIO_A_IRQ0_SET); // bit 31 now set
		check_word("cpu_dout pend0 chained", cpu_dout, pend0_view());
		check_word("firq_n", firq_n, firq_n_expected());

		mask = $urandom;
		write_reg(`CLIO_A_CSYSBITS, mask);
		check_word("cpu_dout csysbits", cpu_dout, mask);
		mask = $urandom % 2048; // vint holds a line number only
		write_reg(`CLIO_A_VINT0, mask);
		check_word("cpu_dout vint0", cpu_dout, mask);

		// vcnt first so its load cannot hide the hcnt wrap
		write_reg(`CLIO_A_VCNT, `CLIO_VCNT_MAX);
		write_reg(`CLIO_A_HCNT, `CLIO_HCNT_MAX);
		read_reg(`CLIO_A_VCNT);
		check_word("cpu_dout vcnt", cpu_dout, 32'd1 << `CLIO_FIELD_SHIFT); // line 0 of field 1
		read_reg(`CLIO_A_HCNT);
		check_word("cpu_dout hcnt", cpu_dout, 32'd1);

		line = 1 + $urandom % 262;
		write_reg(`CLIO_A_VINT0, line);
		write_reg(`CLIO_A_VCNT, line - 1);
		write_reg(`CLIO_A_HCNT, 1570); // 20 clocks before the line starts
		write_reg(`CLIO_A_IRQ0_CLR, 32'd1);
		read_reg(`CLIO_A_IRQ0_SET);
		waited = 0;
		while (cpu_dout[0] !== 1'b1 && waited < 1591) begin
			@(posedge clk_25m);
			#1 waited++;
		end
		if (cpu_dout[0] !== 1'b1) begin
			$display("STATUS: FAIL");
			$fatal(1, "vint0 at line %0d never set bank 0 pending bit 0", line);
		end
		write_reg(`CLIO_A_IRQ0_CLR, 32'd1);
		check_word("cpu_dout pend0 bit 0", cpu_dout & 32'd1, 32'd0);

		repeat (2) @(posedge clk_25m);
		#1;
		if (dut0.chk0.err_count == 0) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			$display("STATUS: FAIL");
			$fatal(1, "bound assertions reported errors");
		end
	end

endmodule
